// File: Bender.yml
package:
  name: rv32i_decode

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/decode_pkg.sv
      - design/register_file.sv
      - design/imm_gen.sv
      - design/control_decoder.sv
      - design/bubble_ctrl.sv
      - design/decode_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_decode.sv

// File: design/bubble_ctrl.sv
/*
 * bubble control
 * nop counter after jumps and branches, load-use hazard detection
 */
`timescale 1ns/1ns
`include "decode_cfg.svh"

module bubble_ctrl
   import decode_pkg::*;
(
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   jump_or_branch, // from control_decoder
   input  instr_u                 instr_raw,      // fetch word, before nop substitution
   input  logic                   ex_load,        // execute holds a load
   input  logic [`REG_ADDR_W-1:0] ex_rd,
   output logic                   insert_nop,
   output logic                   load_hazard_stall
);

   logic [`NOP_CNT_W-1:0] nop_cnt;
   logic [1:0]            src_used; // {rs2, rs1}

   // ##############################
   // post-jump bubble counter
   // ##############################
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         nop_cnt <= '0;
      end else if (jump_or_branch) begin
         nop_cnt <= `NOP_CNT_W'(`BUBBLE_CNT);
      end else if (nop_cnt != '0) begin
         nop_cnt <= nop_cnt - 1'b1;
      end
   end

   // ##############################
   // load-use compare
   // ##############################
   always_comb begin
      case (instr_raw.r.opcode)
         OPC_OP, OPC_BRANCH, OPC_STORE: src_used = 2'b11;
         OPC_LOAD, OPC_IMM, OPC_JALR:   src_used = 2'b01; // rs1 only
         default:                       src_used = 2'b00; // lui, auipc, jal
      endcase
   end

   assign load_hazard_stall = ex_load &
                              ((src_used[0] & (instr_raw.r.rs1 == ex_rd)) |
                               (src_used[1] & (instr_raw.r.rs2 == ex_rd)));

   assign insert_nop = (nop_cnt != '0) | load_hazard_stall;

   // a jump seen during a bubble would mean the nop substitution leaked
   a_no_jump_in_bubble : assert property (
      @(posedge clk) disable iff (!rstn) (nop_cnt != '0) |-> !jump_or_branch
   ) else $error("bubble_ctrl jump or branch decoded during a bubble");

endmodule

// File: design/control_decoder.sv
/*
 * control decoder
 * opcode, funct3 and funct7 to ALU, memory, branch, jump and writeback controls
 */
`timescale 1ns/1ns

module control_decoder
   import decode_pkg::*;
(
   input  instr_u     instr,
   output alu_op_e    alu_op,
   output alu_a_sel_e alu_a_sel,
   output alu_b_sel_e alu_b_sel,
   output wb_sel_e    wb_sel,
   output logic       reg_write,
   output logic       dmem_req,
   output logic       dmem_write,
   output logic       dmem_unsigned,
   output mem_size_e  dmem_size,
   output logic       branch_enable,
   output branch_op_e branch_op,
   output logic       jump_request,
   output logic       pc_stall,
   output logic       jalr_lsb_clear,
   output logic       jump_or_branch // to bubble counter
);

   logic rd_nz; // rd != x0

   // shared by OP and OP-IMM, alt is funct7[5]
   function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  return alt ? ALU_SUB : ALU_ADD;
         3'b001:  return ALU_SLL;
         3'b010:  return ALU_SLT;
         3'b011:  return ALU_SLTU;
         3'b100:  return ALU_XOR;
         3'b101:  return alt ? ALU_SRA : ALU_SRL;
         3'b110:  return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   // writes to x0 dropped here, so the canonical nop writes nothing
   assign rd_nz = |instr.r.rd;

   always_comb begin
      // defaults are the nop controls
      alu_op         = ALU_ADD;
      alu_a_sel      = ALU_RS1;
      alu_b_sel      = ALU_RS2;
      wb_sel         = WB_ALU_OUT;
      reg_write      = 1'b0;
      dmem_req       = 1'b0;
      dmem_write     = 1'b0;
      dmem_unsigned  = 1'b0;
      dmem_size      = WORD;
      branch_enable  = 1'b0;
      branch_op      = CMP_BEQ;
      jump_request   = 1'b0;
      pc_stall       = 1'b0;
      jalr_lsb_clear = 1'b0;
      jump_or_branch = 1'b0;

      case (instr.r.opcode)
         OPC_OP: begin
            alu_op    = alu_from_funct(instr.r.funct3, instr.r.funct7[5]);
            reg_write = rd_nz;
         end
         OPC_IMM: begin
            // funct7 only meaningful for the shifts, addi has imm bits there
            alu_op    = alu_from_funct(instr.i.funct3,
                                       instr.r.funct7[5] & (instr.i.funct3 == 3'b101));
            alu_b_sel = ALU_IMM;
            reg_write = rd_nz;
         end
         OPC_LOAD: begin
            alu_b_sel     = ALU_IMM; // rs1 + imm
            wb_sel        = WB_MEM_LOAD;
            reg_write     = rd_nz;
            dmem_req      = 1'b1;
            dmem_unsigned = instr.i.funct3[2]; // lbu, lhu
            case (instr.i.funct3[1:0])
               2'b00:   dmem_size = BYTE;
               2'b01:   dmem_size = HALF;
               default: dmem_size = WORD;
            endcase
         end
         OPC_STORE: begin
            alu_b_sel  = ALU_IMM;
            dmem_req   = 1'b1;
            dmem_write = 1'b1;
            case (instr.i.funct3[1:0])
               2'b00:   dmem_size = BYTE;
               2'b01:   dmem_size = HALF;
               default: dmem_size = WORD;
            endcase
         end
         OPC_LUI: begin
            alu_a_sel = ALU_ZERO; // 0 + imm
            alu_b_sel = ALU_IMM;
            reg_write = rd_nz;
         end
         OPC_AUIPC: begin
            alu_a_sel = ALU_PC;
            alu_b_sel = ALU_IMM;
            reg_write = rd_nz;
         end
         OPC_JAL: begin
            alu_a_sel      = ALU_PC; // target pc + imm
            alu_b_sel      = ALU_IMM;
            wb_sel         = WB_PC_PLS4;
            reg_write      = rd_nz;
            jump_request   = 1'b1;
            jump_or_branch = 1'b1;
         end
         OPC_JALR: begin
            if (instr.i.funct3 == 3'b000) begin // other funct3 stay nop
               alu_b_sel      = ALU_IMM;
               wb_sel         = WB_PC_PLS4;
               reg_write      = rd_nz;
               jump_request   = 1'b1;
               jalr_lsb_clear = 1'b1; // (rs1 + imm) & ~1
               jump_or_branch = 1'b1;
            end
         end
         OPC_BRANCH: begin
            if (instr.r.funct3[2:1] != 2'b01) begin // 010, 011 reserved
               alu_a_sel      = ALU_PC;
               alu_b_sel      = ALU_IMM;
               branch_enable  = 1'b1;
               branch_op      = branch_op_e'(instr.r.funct3);
               pc_stall       = 1'b1;
               jump_or_branch = 1'b1;
            end
         end
         default: ; // unknown opcode, nop controls
      endcase
   end

endmodule

// File: design/decode_cfg.svh
/*
 * decode stage configuration
 * widths and fixed constants for the RV32I decode stage
 */
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// datapath and instruction width
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5
`define NUM_REGS   32

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

// ##############################
// bubble injection
// ##############################
`define BUBBLE_CNT 2 // nops after jal, jalr, branch
`define NOP_CNT_W  2 // must hold BUBBLE_CNT

`endif

// File: design/decode_pkg.sv
/*
 * decode package
 * opcode and control encodings, instruction format views
 */
package decode_pkg;

   // ##############################
   // encodings
   // ##############################
   typedef enum logic [6:0] {
      OPC_LOAD   = 7'b0000011,
      OPC_IMM    = 7'b0010011,
      OPC_AUIPC  = 7'b0010111,
      OPC_STORE  = 7'b0100011,
      OPC_OP     = 7'b0110011,
      OPC_LUI    = 7'b0110111,
      OPC_BRANCH = 7'b1100011,
      OPC_JALR   = 7'b1100111,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
      ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
   } alu_op_e;

   typedef enum logic [1:0] {ALU_RS1, ALU_PC, ALU_ZERO} alu_a_sel_e;
   typedef enum logic {ALU_RS2, ALU_IMM} alu_b_sel_e;
   typedef enum logic [1:0] {WB_ALU_OUT, WB_MEM_LOAD, WB_PC_PLS4} wb_sel_e;

   // same values as the branch funct3
   typedef enum logic [2:0] {
      CMP_BEQ  = 3'b000,
      CMP_BNE  = 3'b001,
      CMP_BLT  = 3'b100,
      CMP_BGE  = 3'b101,
      CMP_BLTU = 3'b110,
      CMP_BGEU = 3'b111
   } branch_op_e;

   typedef enum logic [1:0] {BYTE = 2'd0, HALF = 2'd1, WORD = 2'd2} mem_size_e;

   // ##############################
   // instruction formats
   // ##############################
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      opcode_e    opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      opcode_e    opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      opcode_e     opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      opcode_e    opcode;
   } j_fmt_t;

   // one word, six views
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      u_fmt_t u;
      j_fmt_t j;
   } instr_u;

endpackage

// File: design/decode_stage.sv
/*
 * RV32I decode stage
 * nop substitution, register read, decode, and the registers toward execute
 */
`timescale 1ns/1ns
`include "decode_cfg.svh"

module decode_stage
   import decode_pkg::*;
(
   input  logic                   clk,
   input  logic                   rstn,
   // from fetch
   input  logic [`XLEN-1:0]       instruction_in,
   input  logic [`XLEN-1:0]       pc_in,
   input  logic [`XLEN-1:0]       pc_pls4_in,
   // from writeback
   input  logic                   wrb_rd_write,
   input  logic [`REG_ADDR_W-1:0] wrb_rd_addr,
   input  logic [`XLEN-1:0]       wrb_rd_data,
   // data toward execute
   output logic [`XLEN-1:0]       pc,
   output logic [`XLEN-1:0]       pc_pls4,
   output logic [`XLEN-1:0]       rs1_data,
   output logic [`XLEN-1:0]       rs2_data,
   output logic [`REG_ADDR_W-1:0] rd_addr,
   output logic [`XLEN-1:0]       immediate,
   // controls toward execute
   output alu_op_e                alu_op,
   output alu_a_sel_e             alu_a_sel,
   output alu_b_sel_e             alu_b_sel,
   output wb_sel_e                wb_sel,
   output logic                   reg_write,
   output logic                   dmem_req,
   output logic                   dmem_write,
   output logic                   dmem_unsigned,
   output mem_size_e              dmem_size,
   output logic                   branch_enable,
   output branch_op_e             branch_op,
   output logic                   jump_request,
   output logic                   pc_stall,
   output logic                   jalr_lsb_clear,
   output logic                   load_hazard_stall // combinational, to fetch
);

   instr_u           instr_eff; // instruction actually decoded
   logic             insert_nop;
   logic             jump_or_branch;
   logic [`XLEN-1:0] rs1_data_nxt, rs2_data_nxt, imm_nxt;
   alu_op_e          alu_op_nxt;
   alu_a_sel_e       alu_a_sel_nxt;
   alu_b_sel_e       alu_b_sel_nxt;
   wb_sel_e          wb_sel_nxt;
   mem_size_e        dmem_size_nxt;
   branch_op_e       branch_op_nxt;
   logic             reg_write_nxt, dmem_req_nxt, dmem_write_nxt, dmem_unsigned_nxt;
   logic             branch_enable_nxt, jump_request_nxt, pc_stall_nxt, jalr_lsb_clear_nxt;

   assign instr_eff = insert_nop ? `NOP_INSTR : instruction_in;

   // ##############################
   // submodules
   // ##############################
   register_file u_rf (
      .clk      (clk),
      .wr_en    (wrb_rd_write),
      .wr_addr  (wrb_rd_addr),
      .wr_data  (wrb_rd_data),
      .rs1_addr (instr_eff.r.rs1),
      .rs2_addr (instr_eff.r.rs2),
      .rs1_data (rs1_data_nxt),
      .rs2_data (rs2_data_nxt)
   );

   imm_gen u_imm (.instr(instr_eff), .imm(imm_nxt));

   control_decoder u_dec (
      .instr          (instr_eff),
      .alu_op         (alu_op_nxt),
      .alu_a_sel      (alu_a_sel_nxt),
      .alu_b_sel      (alu_b_sel_nxt),
      .wb_sel         (wb_sel_nxt),
      .reg_write      (reg_write_nxt),
      .dmem_req       (dmem_req_nxt),
      .dmem_write     (dmem_write_nxt),
      .dmem_unsigned  (dmem_unsigned_nxt),
      .dmem_size      (dmem_size_nxt),
      .branch_enable  (branch_enable_nxt),
      .branch_op      (branch_op_nxt),
      .jump_request   (jump_request_nxt),
      .pc_stall       (pc_stall_nxt),
      .jalr_lsb_clear (jalr_lsb_clear_nxt),
      .jump_or_branch (jump_or_branch)
   );

   bubble_ctrl u_bub (
      .clk               (clk),
      .rstn              (rstn),
      .jump_or_branch    (jump_or_branch),
      .instr_raw         (instruction_in), // hazard looks at the real fetch word
      .ex_load           (dmem_req & ~dmem_write),
      .ex_rd             (rd_addr),
      .insert_nop        (insert_nop),
      .load_hazard_stall (load_hazard_stall)
   );

   // ##############################
   // control registers
   // ##############################
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         alu_op         <= ALU_ADD;
         alu_a_sel      <= ALU_RS1;
         alu_b_sel      <= ALU_RS2;
         wb_sel         <= WB_ALU_OUT;
         reg_write      <= 1'b0;
         dmem_req       <= 1'b0;
         dmem_write     <= 1'b0;
         dmem_unsigned  <= 1'b0;
         dmem_size      <= WORD;
         branch_enable  <= 1'b0;
         branch_op      <= CMP_BEQ;
         jump_request   <= 1'b0;
         pc_stall       <= 1'b0;
         jalr_lsb_clear <= 1'b0;
      end else begin
         alu_op         <= alu_op_nxt;
         alu_a_sel      <= alu_a_sel_nxt;
         alu_b_sel      <= alu_b_sel_nxt;
         wb_sel         <= wb_sel_nxt;
         reg_write      <= reg_write_nxt;
         dmem_req       <= dmem_req_nxt;
         dmem_write     <= dmem_write_nxt;
         dmem_unsigned  <= dmem_unsigned_nxt;
         dmem_size      <= dmem_size_nxt;
         branch_enable  <= branch_enable_nxt;
         branch_op      <= branch_op_nxt;
         jump_request   <= jump_request_nxt;
         pc_stall       <= pc_stall_nxt;
         jalr_lsb_clear <= jalr_lsb_clear_nxt;
      end
   end

   // data registers, qualified by the controls above
   always_ff @(posedge clk) begin
      pc        <= pc_in;
      pc_pls4   <= pc_pls4_in;
      rs1_data  <= rs1_data_nxt;
      rs2_data  <= rs2_data_nxt;
      rd_addr   <= instr_eff.r.rd;
      immediate <= imm_nxt;
   end

endmodule

// File: design/imm_gen.sv
/*
 * immediate generator
 * picks the I/S/B/U/J layout by opcode and sign extends to XLEN
 */
`timescale 1ns/1ns
`include "decode_cfg.svh"

module imm_gen
   import decode_pkg::*;
(
   input  instr_u             instr,
   output logic [`XLEN-1:0]   imm
);

   always_comb begin
      case (instr.r.opcode)
         OPC_LOAD, OPC_IMM, OPC_JALR: // i type
            imm = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
         OPC_STORE:                   // s type
            imm = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
         OPC_BRANCH: begin            // b type, bit 0 always zero
            imm = {{(`XLEN-12){instr.b.imm12}}, instr.b.imm11,
                   instr.b.imm10_5, instr.b.imm4_1, 1'b0};
         end
         OPC_LUI, OPC_AUIPC:          // upper 20, low bits zero
            imm = {instr.u.imm, 12'b0};
         OPC_JAL: begin               // j type
            imm = {{(`XLEN-20){instr.j.imm20}}, instr.j.imm19_12,
                   instr.j.imm11, instr.j.imm10_1, 1'b0};
         end
         default:
            imm = '0; // OP and unknown
      endcase
   end

endmodule

// File: design/register_file.sv
/*
 * register file
 * 32 x 32 array, one write port, two async read ports, x0 tied to zero
 */
`timescale 1ns/1ns
`include "decode_cfg.svh"

module register_file (
   input  logic                   clk,
   input  logic                   wr_en,   // from writeback
   input  logic [`REG_ADDR_W-1:0] wr_addr,
   input  logic [`XLEN-1:0]       wr_data,
   input  logic [`REG_ADDR_W-1:0] rs1_addr,
   input  logic [`REG_ADDR_W-1:0] rs2_addr,
   output logic [`XLEN-1:0]       rs1_data,
   output logic [`XLEN-1:0]       rs2_data
);

   logic [`XLEN-1:0] regs [`NUM_REGS]; // no reset on the array

   // write on the edge, x0 never written
   always_ff @(posedge clk) begin
      if (wr_en && (wr_addr != '0)) begin
         regs[wr_addr] <= wr_data;
      end
   end

   // reads see the old value during a same-cycle write
   assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

   // writeback must not hand over a floating address
   a_wr_addr_known : assert property (
      @(posedge clk) wr_en |-> !$isunknown(wr_addr)
   ) else $error("register_file write with unknown address");

endmodule

// File: src.f
+incdir+design
design/decode_pkg.sv
design/register_file.sv
design/imm_gen.sv
design/control_decoder.sv
design/bubble_ctrl.sv
design/decode_stage.sv
tb/tb_decode.sv

// File: tb/tb_decode.sv
/*
 * testbench for the RV32I decode stage
 * LCG stimulus, reference decode model, assertion checks at the falling edge
 */
`timescale 1ns/1ns
`include "decode_cfg.svh"

module tb_decode
   import decode_pkg::*;
();

   localparam int N_ALU = 60;
   localparam int N_MEM = 40;
   localparam int N_JB  = 30;
   localparam int PLAN_CYCLES = 8 + 31 + N_ALU + 2 * N_MEM + 3 * N_JB + 40;
   localparam int MAX_CYCLES  = 2 * PLAN_CYCLES; // timeout limit

   // expected control bundle
   typedef struct packed {
      alu_op_e    alu_op;
      alu_a_sel_e a_sel;
      alu_b_sel_e b_sel;
      wb_sel_e    wb;
      logic       rw, req, wr, uns;
      mem_size_e  size;
      logic       br;
      branch_op_e bop;
      logic       jmp, pcs, lsb;
   } ctrl_t;

   logic                   clk = 1'b0;
   logic                   rstn;
   logic [`XLEN-1:0]       instruction_in, pc_in, pc_pls4_in;
   logic                   wrb_rd_write;
   logic [`REG_ADDR_W-1:0] wrb_rd_addr;
   logic [`XLEN-1:0]       wrb_rd_data;
   logic [`XLEN-1:0]       pc, pc_pls4, rs1_data, rs2_data, immediate;
   logic [`REG_ADDR_W-1:0] rd_addr;
   alu_op_e                alu_op;
   alu_a_sel_e             alu_a_sel;
   alu_b_sel_e             alu_b_sel;
   wb_sel_e                wb_sel;
   mem_size_e              dmem_size;
   branch_op_e             branch_op;
   logic                   reg_write, dmem_req, dmem_write, dmem_unsigned;
   logic                   branch_enable, jump_request, pc_stall, jalr_lsb_clear;
   logic                   load_hazard_stall;

   // model state
   ctrl_t            exp_c, dec_now;
   logic [1:0]       exp_cnt;
   logic             exp_stall, exp_nop, data_ok = 1'b0;
   logic [`XLEN-1:0] eff, exp_pc, exp_pc4, exp_rs1, exp_rs2, exp_imm;
   logic [4:0]       exp_rd;
   logic [`XLEN-1:0] ref_regs [32];
   logic [31:0]      seed = 32'd40824;
   logic [31:0]      pc_cnt = '0;
   int               cycles = 0;

   always #50 clk = ~clk; // 100 ns period

   decode_stage dut (.*);

   // ##############################
   // helpers
   // ##############################
   function automatic logic [31:0] rand32();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] e, input logic [31:0] a);
      $display("ERR %s expected %h actual %h", name, e, a);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   function automatic ctrl_t ctrl_nop();
      return '{ALU_ADD, ALU_RS1, ALU_RS2, WB_ALU_OUT, 1'b0, 1'b0, 1'b0, 1'b0, WORD,
               1'b0, CMP_BEQ, 1'b0, 1'b0, 1'b0};
   endfunction

   // funct3 / alt bit to ALU operation, per the RV32I tables
   function automatic alu_op_e alu_ref(input logic [2:0] f3, input logic alt);
      alu_op_e ops [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                           ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
      if (alt && f3 == 3'd0) return ALU_SUB;
      if (alt && f3 == 3'd5) return ALU_SRA;
      return ops[f3];
   endfunction

   function automatic mem_size_e size_ref(input logic [1:0] f);
      return (f == 2'd0) ? BYTE : (f == 2'd1) ? HALF : WORD;
   endfunction

   function automatic ctrl_t decode_ref(input logic [31:0] w);
      ctrl_t      d;
      logic [2:0] f3;
      logic       nz;
      d  = ctrl_nop();
      f3 = w[14:12];
      nz = (w[11:7] != 5'd0); // x0 never written
      case (w[6:0])
         7'b0110011: begin
            d.alu_op = alu_ref(f3, w[30]);
            d.rw     = nz;
         end
         7'b0010011: begin
            d.alu_op = alu_ref(f3, w[30] && f3 == 3'd5); // only srai uses alt
            d.b_sel  = ALU_IMM;
            d.rw     = nz;
         end
         7'b0000011: begin
            d.b_sel = ALU_IMM;
            d.wb    = WB_MEM_LOAD;
            d.rw    = nz;
            d.req   = 1'b1;
            d.uns   = f3[2];
            d.size  = size_ref(f3[1:0]);
         end
         7'b0100011: begin
            d.b_sel = ALU_IMM;
            d.req   = 1'b1;
            d.wr    = 1'b1;
            d.size  = size_ref(f3[1:0]);
         end
         7'b0110111: begin
            d.a_sel = ALU_ZERO;
            d.b_sel = ALU_IMM;
            d.rw    = nz;
         end
         7'b0010111: begin
            d.a_sel = ALU_PC;
            d.b_sel = ALU_IMM;
            d.rw    = nz;
         end
         7'b1101111: begin
            d.a_sel = ALU_PC;
            d.b_sel = ALU_IMM;
            d.wb    = WB_PC_PLS4;
            d.rw    = nz;
            d.jmp   = 1'b1;
         end
         7'b1100111: if (f3 == 3'd0) begin
            d.b_sel = ALU_IMM;
            d.wb    = WB_PC_PLS4;
            d.rw    = nz;
            d.jmp   = 1'b1;
            d.lsb   = 1'b1;
         end
         7'b1100011: if (f3[2:1] != 2'b01) begin
            d.a_sel = ALU_PC;
            d.b_sel = ALU_IMM;
            d.br    = 1'b1;
            d.pcs   = 1'b1;
            d.bop   = branch_op_e'(f3);
         end
         default: ;
      endcase
      return d;
   endfunction

   function automatic logic [31:0] imm_ref(input logic [31:0] w);
      case (w[6:0])
         7'b0000011, 7'b0010011, 7'b1100111: return {{20{w[31]}}, w[31:20]};
         7'b0100011: return {{20{w[31]}}, w[31:25], w[11:7]};
         7'b1100011: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         7'b0110111, 7'b0010111: return {w[31:12], 12'b0};
         7'b1101111: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         default: return '0;
      endcase
   endfunction

   // ##############################
   // reference model
   // ##############################
   always_comb begin
      logic u1, u2;
      u1 = 1'b0;
      u2 = 1'b0;
      case (instruction_in[6:0])
         7'b0110011, 7'b1100011, 7'b0100011: begin
            u1 = 1'b1;
            u2 = 1'b1;
         end
         7'b0000011, 7'b0010011, 7'b1100111: u1 = 1'b1;
         default: ;
      endcase
      exp_stall = exp_c.req & ~exp_c.wr &
                  ((u1 & (instruction_in[19:15] == exp_rd)) |
                   (u2 & (instruction_in[24:20] == exp_rd)));
      exp_nop = (exp_cnt != 2'd0) | exp_stall;
      eff     = exp_nop ? `NOP_INSTR : instruction_in;
      dec_now = decode_ref(eff);
   end

   always @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         exp_c   <= ctrl_nop();
         exp_cnt <= 2'd0;
      end else begin
         exp_c <= dec_now;
         if (dec_now.jmp | dec_now.br) exp_cnt <= 2'd2; // two bubbles
         else if (exp_cnt != 2'd0) exp_cnt <= exp_cnt - 2'd1;
      end
   end

   // data side, old value on same-cycle write
   always @(posedge clk) begin
      exp_pc  <= pc_in;
      exp_pc4 <= pc_pls4_in;
      exp_rs1 <= (eff[19:15] == 5'd0) ? '0 : ref_regs[eff[19:15]];
      exp_rs2 <= (eff[24:20] == 5'd0) ? '0 : ref_regs[eff[24:20]];
      exp_rd  <= eff[11:7];
      exp_imm <= imm_ref(eff);
      if (wrb_rd_write && wrb_rd_addr != 5'd0) ref_regs[wrb_rd_addr] <= wrb_rd_data;
      data_ok <= 1'b1;
   end

   // ##############################
   // checks, sampled mid-cycle
   // ##############################
   a_alu_op : assert property (@(negedge clk) alu_op === exp_c.alu_op)
      else report_mismatch("alu_op", exp_c.alu_op, alu_op);
   a_a_sel : assert property (@(negedge clk) alu_a_sel === exp_c.a_sel)
      else report_mismatch("alu_a_sel", exp_c.a_sel, alu_a_sel);
   a_b_sel : assert property (@(negedge clk) alu_b_sel === exp_c.b_sel)
      else report_mismatch("alu_b_sel", exp_c.b_sel, alu_b_sel);
   a_wb_sel : assert property (@(negedge clk) wb_sel === exp_c.wb)
      else report_mismatch("wb_sel", exp_c.wb, wb_sel);
   a_reg_write : assert property (@(negedge clk) reg_write === exp_c.rw)
      else report_mismatch("reg_write", exp_c.rw, reg_write);
   a_dmem_req : assert property (@(negedge clk) dmem_req === exp_c.req)
      else report_mismatch("dmem_req", exp_c.req, dmem_req);
   a_dmem_write : assert property (@(negedge clk) dmem_write === exp_c.wr)
      else report_mismatch("dmem_write", exp_c.wr, dmem_write);
   a_dmem_uns : assert property (@(negedge clk) dmem_unsigned === exp_c.uns)
      else report_mismatch("dmem_unsigned", exp_c.uns, dmem_unsigned);
   a_dmem_size : assert property (@(negedge clk) dmem_size === exp_c.size)
      else report_mismatch("dmem_size", exp_c.size, dmem_size);
   a_branch_en : assert property (@(negedge clk) branch_enable === exp_c.br)
      else report_mismatch("branch_enable", exp_c.br, branch_enable);
   a_branch_op : assert property (@(negedge clk) branch_op === exp_c.bop)
      else report_mismatch("branch_op", exp_c.bop, branch_op);
   a_jump : assert property (@(negedge clk) jump_request === exp_c.jmp)
      else report_mismatch("jump_request", exp_c.jmp, jump_request);
   a_pc_stall : assert property (@(negedge clk) pc_stall === exp_c.pcs)
      else report_mismatch("pc_stall", exp_c.pcs, pc_stall);
   a_lsb_clear : assert property (@(negedge clk) jalr_lsb_clear === exp_c.lsb)
      else report_mismatch("jalr_lsb_clear", exp_c.lsb, jalr_lsb_clear);
   a_hazard : assert property (@(negedge clk) load_hazard_stall === exp_stall)
      else report_mismatch("load_hazard_stall", exp_stall, load_hazard_stall);
   // data outputs have no reset, checked once the first edge has passed
   a_pc : assert property (@(negedge clk) !data_ok || pc === exp_pc)
      else report_mismatch("pc", exp_pc, pc);
   a_pc4 : assert property (@(negedge clk) !data_ok || pc_pls4 === exp_pc4)
      else report_mismatch("pc_pls4", exp_pc4, pc_pls4);
   a_rs1 : assert property (@(negedge clk) !data_ok || rs1_data === exp_rs1)
      else report_mismatch("rs1_data", exp_rs1, rs1_data);
   a_rs2 : assert property (@(negedge clk) !data_ok || rs2_data === exp_rs2)
      else report_mismatch("rs2_data", exp_rs2, rs2_data);
   a_rd : assert property (@(negedge clk) !data_ok || rd_addr === exp_rd)
      else report_mismatch("rd_addr", exp_rd, rd_addr);
   a_imm : assert property (@(negedge clk) !data_ok || immediate === exp_imm)
      else report_mismatch("immediate", exp_imm, immediate);

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > MAX_CYCLES) begin
         $display("timeout: run went past %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $fatal(1);
      end
   end

   // ##############################
   // stimulus
   // ##############################
   // one instruction, held by fetch while the stage stalls
   task automatic present_with_wb(input logic [31:0] w, input logic we,
                                  input logic [4:0] wa, input logic [31:0] wd);
      logic held;
      instruction_in = w;
      pc_in          = pc_cnt;
      pc_pls4_in     = pc_cnt + 32'd4;
      wrb_rd_write   = we;
      wrb_rd_addr    = wa;
      wrb_rd_data    = wd;
      #1 held = exp_stall;
      @(posedge clk);
      #10;
      while (held) begin
         wrb_rd_write = 1'b0; // no writeback during the replay
         #1 held = exp_stall;
         @(posedge clk);
         #10;
      end
      pc_cnt += 32'd4;
   endtask

   task automatic present(input logic [31:0] w);
      logic [31:0] r;
      r = rand32();
      present_with_wb(w, r[0], r[5:1], rand32()); // x0 writes included
   endtask

   function automatic logic [31:0] gen_alu();
      logic [31:0] r;
      logic [2:0]  f3;
      logic [11:0] imm;
      r  = rand32();
      f3 = r[14:12];
      case (rand32() % 4)
         0: return {((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00,
                    r[24:7], 7'b0110011};
         1: begin
            imm = r[31:20];
            if (f3 == 3'd1) imm[11:5] = 7'h00;
            if (f3 == 3'd5) imm[11:5] = r[30] ? 7'h20 : 7'h00; // srai or srli
            return {imm, r[19:15], f3, r[11:7], 7'b0010011};
         end
         2: return {r[31:7], 7'b0110111};
         default: return {r[31:7], 7'b0010111};
      endcase
   endfunction

   function automatic logic [31:0] gen_mem();
      logic [31:0] r;
      logic [2:0]  f3;
      r = rand32();
      if (r[0]) begin
         f3 = 3'(rand32() % 5);
         if (f3 > 3'd2) f3 = f3 + 3'd1; // lb lh lw lbu lhu
         return {r[31:15], f3, r[11:7], 7'b0000011};
      end
      f3 = 3'(rand32() % 3);
      return {r[31:15], f3, r[11:7], 7'b0100011};
   endfunction

   function automatic logic [31:0] gen_jb();
      logic [31:0] r;
      logic [2:0]  f3;
      r = rand32();
      case (rand32() % 3)
         0: return {r[31:7], 7'b1101111};
         1: return {r[31:15], 3'd0, r[11:7], 7'b1100111};
         default: begin
            f3 = 3'(rand32() % 6);
            if (f3 > 3'd1) f3 = f3 + 3'd2; // skip reserved 010, 011
            return {r[31:15], f3, r[11:7], 7'b1100011};
         end
      endcase
   endfunction

   initial begin
      logic [31:0] w;
      rstn           = 1'b0;
      instruction_in = `NOP_INSTR;
      pc_in          = '0;
      pc_pls4_in     = 32'd4;
      wrb_rd_write   = 1'b0;
      wrb_rd_addr    = '0;
      wrb_rd_data    = '0;

      // real instructions during reset, controls must stay at reset values
      @(posedge clk);
      for (int i = 0; i < 7; i++) begin
         #10;
         case (i % 3)
            0:       w = gen_jb();
            1:       w = gen_mem();
            default: w = gen_alu();
         endcase
         instruction_in = w & ~32'h01ff_8000; // sources x0, array not yet filled
         @(posedge clk);
      end
      #10 rstn = 1'b1;

      // fill every register before any real read
      for (int i = 1; i < 32; i++) present_with_wb(`NOP_INSTR, 1'b1, 5'(i), rand32());

      for (int i = 0; i < N_ALU; i++) present(gen_alu());
      for (int i = 0; i < N_MEM; i++) begin
         present(gen_mem());
         present(gen_alu()); // may hit a load-use stall
      end
      for (int i = 0; i < N_JB; i++) begin
         present(gen_jb());
         present(gen_alu()); // both bubbled
         present(gen_alu());
      end

      // directed load-use cases on x5
      present({12'h010, 5'd1, 3'b010, 5'd5, 7'b0000011}); // lw x5
      present({7'h00, 5'd1, 5'd5, 3'b000, 5'd6, 7'b0110011}); // add x6,x5,x1 stalls
      present({12'h010, 5'd1, 3'b010, 5'd5, 7'b0000011});
      present({12'h005, 5'd2, 3'b000, 5'd7, 7'b0010011}); // rs2 field unused
      present({12'h010, 5'd1, 3'b010, 5'd5, 7'b0000011});
      present({20'h00528, 5'd5, 7'b0110111}); // lui, both source fields read as x5
      present({12'h010, 5'd1, 3'b010, 5'd5, 7'b0000011});
      present({7'h00, 5'd5, 5'd3, 3'b010, 5'd4, 7'b0100011}); // sw rs2=x5 stalls
      present({12'h010, 5'd1, 3'b010, 5'd5, 7'b0000011});
      present({7'h00, 5'd2, 5'd5, 3'b000, 5'd8, 7'b1100011}); // beq on x5
      present(gen_alu());
      present(gen_alu());

      // register file write then read, x0 stays zero
      present_with_wb(`NOP_INSTR, 1'b1, 5'd9, 32'h9009_0009);
      present_with_wb({7'h00, 5'd0, 5'd9, 3'b000, 5'd1, 7'b0110011}, 1'b0, 5'd0, '0);
      present_with_wb(`NOP_INSTR, 1'b1, 5'd0, 32'hffff_ffff);
      present_with_wb({7'h00, 5'd0, 5'd0, 3'b000, 5'd2, 7'b0110011}, 1'b0, 5'd0, '0);
      present(`NOP_INSTR);
      @(negedge clk);

      $display("TEST PASSED");
      $finish;
   end

endmodule
